// ==== include/rv32_opcodes.svh ====
`ifndef RV32_OPCODES_SVH
`define RV32_OPCODES_SVH

// major opcodes of the kept instruction groups
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011

// funct3 of srli/srai, the only imm op that reads funct7
`define F3_SR     3'b101

// funct7 bit positions
// bit 0 marks the M extension, bit 5 selects sub/sra/srai
`define F7_M_BIT    0
`define F7_ALT_BIT  5

`endif

// ==== hdl/rv32_dispatch_pkg.sv ====
`default_nettype none

`include "rv32_opcodes.svh"

package rv32_dispatch_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    // 16 reorder-buffer entries
    localparam int ROB_IDX_W  = 4;

    localparam logic [6:0] OPC_LUI   = `OP_LUI;
    localparam logic [6:0] OPC_AUIPC = `OP_AUIPC;
    localparam logic [6:0] OPC_JAL   = `OP_JAL;
    localparam logic [6:0] OPC_IMM   = `OP_IMM;
    localparam logic [6:0] OPC_REG   = `OP_REG;
    localparam logic [2:0] F3_SR     = `F3_SR;
    localparam int         F7_M_IDX   = `F7_M_BIT;
    localparam int         F7_ALT_IDX = `F7_ALT_BIT;

    // destination of the head instruction
    typedef enum logic [1:0] {
        CLS_ROB_ONLY,
        CLS_ALU,
        CLS_MULDIV,
        CLS_HOLD
    } disp_class_e;

    typedef struct packed {
        disp_class_e           cls;
        logic [2:0]            funct3;
        logic                  funct7_b;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic                  uses_rs2;
        logic [XLEN-1:0]       imm;
        // result already known at decode for lui, auipc, jal
        logic [XLEN-1:0]       early_rd_v;
    } decoded_t;

    typedef struct packed {
        logic                 valid;
        logic [2:0]           funct3;
        logic                 funct7;
        logic                 rs1_renamed;
        logic [XLEN-1:0]      rs1_data;
        logic                 rs2_renamed;
        logic [XLEN-1:0]      rs2_data;
        logic [ROB_IDX_W-1:0] rob_id;
    } rs_entry_t;

    typedef struct packed {
        logic                  valid;
        logic                  rd_valid;
        logic [XLEN-1:0]       rd_v;
        logic                  regf_we;
        logic [REG_ADDR_W-1:0] rd_s;
    } rob_entry_t;

endpackage

`default_nettype wire

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
    input  logic [rv32_dispatch_pkg::XLEN-1:0] inst_i,
    input  logic [rv32_dispatch_pkg::XLEN-1:0] pc_i,
    output rv32_dispatch_pkg::decoded_t        dec_o
);

    import rv32_dispatch_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] i_imm;
    logic [XLEN-1:0] u_imm;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // sign-extended I-immediate, upper U-immediate
    assign i_imm = {{(XLEN-11){inst_i[31]}}, inst_i[30:20]};
    assign u_imm = {inst_i[31:12], 12'h000};

    always_comb begin
        dec_o            = '0;
        dec_o.cls        = CLS_HOLD;
        dec_o.funct3     = funct3;
        dec_o.rs1        = inst_i[19:15];
        dec_o.rs2        = inst_i[24:20];
        dec_o.rd         = inst_i[11:7];
        dec_o.imm        = i_imm;
        dec_o.uses_rs2   = 1'b0;
        dec_o.funct7_b   = 1'b0;
        dec_o.early_rd_v = '0;

        case (opcode)
            OPC_LUI: begin
                dec_o.cls        = CLS_ROB_ONLY;
                dec_o.early_rd_v = u_imm;
            end

            OPC_AUIPC: begin
                dec_o.cls        = CLS_ROB_ONLY;
                dec_o.early_rd_v = pc_i + u_imm;
            end

            // jal completes here, only the link value is written
            OPC_JAL: begin
                dec_o.cls        = CLS_ROB_ONLY;
                dec_o.early_rd_v = pc_i + 32'd4;
            end

            OPC_IMM: begin
                dec_o.cls = CLS_ALU;
                // srai vs srli
                if (funct3 == F3_SR) begin
                    dec_o.funct7_b = funct7[F7_ALT_IDX];
                end
            end

            OPC_REG: begin
                dec_o.uses_rs2 = 1'b1;
                if (funct7[F7_M_IDX]) begin
                    dec_o.cls = CLS_MULDIV;
                end else begin
                    dec_o.cls      = CLS_ALU;
                    dec_o.funct7_b = funct7[F7_ALT_IDX];
                end
            end

            // loads, stores, branches, jalr, system: stay in the queue
            default: begin
                dec_o.cls = CLS_HOLD;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/dispatch_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module dispatch_ctrl (
    input  rv32_dispatch_pkg::decoded_t                    dec_i,
    input  logic                                           inst_empty_i,
    input  logic                                           rob_full_i,
    input  logic                                           rs_alu_full_i,
    input  logic                                           rs_muldiv_full_i,
    input  logic [rv32_dispatch_pkg::ROB_IDX_W-1:0]        rob_tail_i,
    input  logic                                           rs1_renamed_i,
    input  logic [rv32_dispatch_pkg::XLEN-1:0]             rs1_v_i,
    input  logic                                           rs2_renamed_i,
    input  logic [rv32_dispatch_pkg::XLEN-1:0]             rs2_v_i,
    output logic [rv32_dispatch_pkg::REG_ADDR_W-1:0]       rs1_s_o,
    output logic [rv32_dispatch_pkg::REG_ADDR_W-1:0]       rs2_s_o,
    output logic                                           inst_dequeue_o,
    output logic                                           reg_r_o,
    output logic [rv32_dispatch_pkg::REG_ADDR_W-1:0]       rd_r_o,
    output logic [rv32_dispatch_pkg::ROB_IDX_W-1:0]        rob_r_o,
    output rv32_dispatch_pkg::rs_entry_t                   rs_entry_o,
    output rv32_dispatch_pkg::rob_entry_t                  rob_entry_o,
    output logic                                           go_rob_o,
    output logic                                           go_alu_o,
    output logic                                           go_muldiv_o
);

    import rv32_dispatch_pkg::*;

    logic            target_full;
    logic            go;
    logic            to_station;
    logic            rs1_renamed_sel;
    logic            rs2_renamed_sel;
    logic [XLEN-1:0] rs1_data_sel;
    logic [XLEN-1:0] rs2_data_sel;

    // only the station the instruction needs can stall it
    always_comb begin
        case (dec_i.cls)
            CLS_ROB_ONLY: target_full = 1'b0;
            CLS_ALU:      target_full = rs_alu_full_i;
            CLS_MULDIV:   target_full = rs_muldiv_full_i;
            default:      target_full = 1'b1;
        endcase
    end

    assign go         = !inst_empty_i && !rob_full_i && !target_full;
    assign to_station = (dec_i.cls == CLS_ALU) || (dec_i.cls == CLS_MULDIV);

    assign inst_dequeue_o = go;
    assign go_rob_o       = go;
    assign go_alu_o       = go && (dec_i.cls == CLS_ALU);
    assign go_muldiv_o    = go && (dec_i.cls == CLS_MULDIV);

    // register file lookup is same-cycle
    assign rs1_s_o = dec_i.rs1;
    assign rs2_s_o = dec_i.rs2;

    // rename table write, x0 is never renamed
    assign reg_r_o = go && (dec_i.rd != '0);
    assign rd_r_o  = dec_i.rd;
    assign rob_r_o = rob_tail_i;

    // x0 reads as a ready zero
    always_comb begin
        if (dec_i.rs1 == '0) begin
            rs1_renamed_sel = 1'b0;
            rs1_data_sel    = '0;
        end else begin
            rs1_renamed_sel = rs1_renamed_i;
            rs1_data_sel    = rs1_v_i;
        end

        if (!dec_i.uses_rs2) begin
            // immediate takes the rs2 slot
            rs2_renamed_sel = 1'b0;
            rs2_data_sel    = dec_i.imm;
        end else if (dec_i.rs2 == '0) begin
            rs2_renamed_sel = 1'b0;
            rs2_data_sel    = '0;
        end else begin
            rs2_renamed_sel = rs2_renamed_i;
            rs2_data_sel    = rs2_v_i;
        end
    end

    always_comb begin
        rs_entry_o = '0;
        if (to_station) begin
            rs_entry_o.valid       = 1'b1;
            rs_entry_o.funct3      = dec_i.funct3;
            rs_entry_o.funct7      = dec_i.funct7_b;
            rs_entry_o.rs1_renamed = rs1_renamed_sel;
            rs_entry_o.rs1_data    = rs1_data_sel;
            rs_entry_o.rs2_renamed = rs2_renamed_sel;
            rs_entry_o.rs2_data    = rs2_data_sel;
            rs_entry_o.rob_id      = rob_tail_i;
        end
    end

    always_comb begin
        rob_entry_o = '0;
        if (dec_i.cls != CLS_HOLD) begin
            // lui/auipc/jal enter the ROB already complete
            rob_entry_o.valid    = (dec_i.cls == CLS_ROB_ONLY);
            rob_entry_o.rd_valid = (dec_i.cls == CLS_ROB_ONLY);
            rob_entry_o.rd_v     = dec_i.early_rd_v;
            rob_entry_o.regf_we  = 1'b1;
            rob_entry_o.rd_s     = dec_i.rd;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dispatch_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module dispatch_stage (
    input  logic                          clk,
    input  logic                          rst_i,
    input  rv32_dispatch_pkg::rs_entry_t  rs_entry_i,
    input  rv32_dispatch_pkg::rob_entry_t rob_entry_i,
    input  logic                          go_rob_i,
    input  logic                          go_alu_i,
    input  logic                          go_muldiv_i,
    output rv32_dispatch_pkg::rs_entry_t  rs_entry_o,
    output rv32_dispatch_pkg::rob_entry_t rob_entry_o,
    output logic                          rob_enqueue_o,
    output logic                          rs_alu_enqueue_o,
    output logic                          rs_muldiv_enqueue_o
);

    import rv32_dispatch_pkg::*;

    rs_entry_t  rs_entry_q;
    rob_entry_t rob_entry_q;

    // strobes follow the go signals with one cycle of delay
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rob_enqueue_o       <= 1'b0;
            rs_alu_enqueue_o    <= 1'b0;
            rs_muldiv_enqueue_o <= 1'b0;
        end else begin
            rob_enqueue_o       <= go_rob_i;
            rs_alu_enqueue_o    <= go_alu_i;
            rs_muldiv_enqueue_o <= go_muldiv_i;
        end
    end

    // entries hold their value while nothing is dispatched
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rs_entry_q  <= '0;
            rob_entry_q <= '0;
        end else if (go_rob_i || go_alu_i || go_muldiv_i) begin
            rs_entry_q  <= rs_entry_i;
            rob_entry_q <= rob_entry_i;
        end
    end

    assign rs_entry_o  = rs_entry_q;
    assign rob_entry_o = rob_entry_q;

endmodule

`default_nettype wire

// ==== hdl/decode_dispatch.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_dispatch (
    input  logic                                     clk,
    input  logic                                     rst_i,
    // instruction queue
    input  logic [rv32_dispatch_pkg::XLEN-1:0]       inst_i,
    input  logic [rv32_dispatch_pkg::XLEN-1:0]       pc_i,
    input  logic                                     inst_empty_i,
    output logic                                     inst_dequeue_o,
    // consumers
    input  logic                                     rob_full_i,
    input  logic                                     rs_alu_full_i,
    input  logic                                     rs_muldiv_full_i,
    input  logic [rv32_dispatch_pkg::ROB_IDX_W-1:0]  rob_tail_i,
    output rv32_dispatch_pkg::rs_entry_t             rs_entry_o,
    output rv32_dispatch_pkg::rob_entry_t            rob_entry_o,
    output logic                                     rob_enqueue_o,
    output logic                                     rs_alu_enqueue_o,
    output logic                                     rs_muldiv_enqueue_o,
    // register file and rename table
    output logic [rv32_dispatch_pkg::REG_ADDR_W-1:0] rs1_s_o,
    output logic [rv32_dispatch_pkg::REG_ADDR_W-1:0] rs2_s_o,
    input  logic                                     rs1_renamed_i,
    input  logic [rv32_dispatch_pkg::XLEN-1:0]       rs1_v_i,
    input  logic                                     rs2_renamed_i,
    input  logic [rv32_dispatch_pkg::XLEN-1:0]       rs2_v_i,
    output logic                                     reg_r_o,
    output logic [rv32_dispatch_pkg::REG_ADDR_W-1:0] rd_r_o,
    output logic [rv32_dispatch_pkg::ROB_IDX_W-1:0]  rob_r_o
);

    import rv32_dispatch_pkg::*;

    decoded_t   dec;
    rs_entry_t  rs_entry_d;
    rob_entry_t rob_entry_d;
    logic       go_rob;
    logic       go_alu;
    logic       go_muldiv;

    inst_decoder u_decoder (
        .inst_i (inst_i),
        .pc_i   (pc_i),
        .dec_o  (dec)
    );

    dispatch_ctrl u_ctrl (
        .dec_i            (dec),
        .inst_empty_i     (inst_empty_i),
        .rob_full_i       (rob_full_i),
        .rs_alu_full_i    (rs_alu_full_i),
        .rs_muldiv_full_i (rs_muldiv_full_i),
        .rob_tail_i       (rob_tail_i),
        .rs1_renamed_i    (rs1_renamed_i),
        .rs1_v_i          (rs1_v_i),
        .rs2_renamed_i    (rs2_renamed_i),
        .rs2_v_i          (rs2_v_i),
        .rs1_s_o          (rs1_s_o),
        .rs2_s_o          (rs2_s_o),
        .inst_dequeue_o   (inst_dequeue_o),
        .reg_r_o          (reg_r_o),
        .rd_r_o           (rd_r_o),
        .rob_r_o          (rob_r_o),
        .rs_entry_o       (rs_entry_d),
        .rob_entry_o      (rob_entry_d),
        .go_rob_o         (go_rob),
        .go_alu_o         (go_alu),
        .go_muldiv_o      (go_muldiv)
    );

    // one register stage between decode and the stations
    dispatch_stage u_stage (
        .clk                 (clk),
        .rst_i               (rst_i),
        .rs_entry_i          (rs_entry_d),
        .rob_entry_i         (rob_entry_d),
        .go_rob_i            (go_rob),
        .go_alu_i            (go_alu),
        .go_muldiv_i         (go_muldiv),
        .rs_entry_o          (rs_entry_o),
        .rob_entry_o         (rob_entry_o),
        .rob_enqueue_o       (rob_enqueue_o),
        .rs_alu_enqueue_o    (rs_alu_enqueue_o),
        .rs_muldiv_enqueue_o (rs_muldiv_enqueue_o)
    );

endmodule

`default_nettype wire

// ==== test/decode_dispatch_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_dispatch_props (
    input logic clk,
    input logic rst_i,
    input logic dequeue_i,
    input logic rob_enq_i,
    input logic alu_enq_i,
    input logic muldiv_enq_i
);

    int fail_count = 0;

    // an instruction targets one station at most
    one_station: assert property (@(posedge clk) disable iff (rst_i)
        !(alu_enq_i && muldiv_enq_i))
        else begin
            fail_count++;
            $error("ALU and mul/div station strobes high in the same cycle");
        end

    // every station entry has its ROB entry beside it
    station_has_rob: assert property (@(posedge clk) disable iff (rst_i)
        (alu_enq_i || muldiv_enq_i) |-> rob_enq_i)
        else begin
            fail_count++;
            $error("station strobe without a ROB enqueue");
        end

    // one-cycle output stage
    dequeue_then_rob: assert property (@(posedge clk) disable iff (rst_i)
        dequeue_i |=> rob_enq_i)
        else begin
            fail_count++;
            $error("dequeue not followed by a ROB enqueue in the next cycle");
        end

endmodule

`default_nettype wire

// ==== test/tb_decode_dispatch.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "rv32_opcodes.svh"

module tb_decode_dispatch;

    import rv32_dispatch_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;

    // expected destination of each row
    localparam logic [1:0] D_NONE = 2'd0;
    localparam logic [1:0] D_ROB  = 2'd1;
    localparam logic [1:0] D_ALU  = 2'd2;
    localparam logic [1:0] D_MD   = 2'd3;

    // source of the expected rs2 slot
    localparam logic [1:0] S_ZERO = 2'd0;
    localparam logic [1:0] S_REG  = 2'd1;
    localparam logic [1:0] S_IMM  = 2'd2;

    typedef struct {
        logic [31:0] inst;
        logic [31:0] pc;
        // rob_full, alu_full, muldiv_full, empty
        logic [3:0]  flags;
        logic [3:0]  tail;
        logic        rs1_ren;
        logic [31:0] rs1_v;
        logic        rs2_ren;
        logic [31:0] rs2_v;
        logic [1:0]  dest;
        logic [4:0]  rd;
        logic [31:0] rd_v;
        logic        f7;
        logic        s1_ren;
        logic [31:0] s1_data;
        logic        s2_ren;
        logic [31:0] s2_data;
    } row_t;

    logic        clk;
    logic        rst;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        inst_empty;
    logic        inst_dequeue;
    logic        rob_full;
    logic        rs_alu_full;
    logic        rs_muldiv_full;
    logic [3:0]  rob_tail;
    rs_entry_t   rs_entry;
    rob_entry_t  rob_entry;
    logic        rob_enqueue;
    logic        rs_alu_enqueue;
    logic        rs_muldiv_enqueue;
    logic [4:0]  rs1_s;
    logic [4:0]  rs2_s;
    logic        rs1_renamed;
    logic [31:0] rs1_v;
    logic        rs2_renamed;
    logic [31:0] rs2_v;
    logic        reg_r;
    logic [4:0]  rd_r;
    logic [3:0]  rob_r;

    row_t   rows[$];
    integer seed = 32'h30d5_1cdc;
    int     checks = 0;
    int     errors = 0;
    logic   table_ready = 1'b0;

    decode_dispatch u_dut (
        .clk                 (clk),
        .rst_i               (rst),
        .inst_i              (inst),
        .pc_i                (pc),
        .inst_empty_i        (inst_empty),
        .inst_dequeue_o      (inst_dequeue),
        .rob_full_i          (rob_full),
        .rs_alu_full_i       (rs_alu_full),
        .rs_muldiv_full_i    (rs_muldiv_full),
        .rob_tail_i          (rob_tail),
        .rs_entry_o          (rs_entry),
        .rob_entry_o         (rob_entry),
        .rob_enqueue_o       (rob_enqueue),
        .rs_alu_enqueue_o    (rs_alu_enqueue),
        .rs_muldiv_enqueue_o (rs_muldiv_enqueue),
        .rs1_s_o             (rs1_s),
        .rs2_s_o             (rs2_s),
        .rs1_renamed_i       (rs1_renamed),
        .rs1_v_i             (rs1_v),
        .rs2_renamed_i       (rs2_renamed),
        .rs2_v_i             (rs2_v),
        .reg_r_o             (reg_r),
        .rd_r_o              (rd_r),
        .rob_r_o             (rob_r)
    );

    bind decode_dispatch decode_dispatch_props u_props (
        .clk          (clk),
        .rst_i        (rst_i),
        .dequeue_i    (inst_dequeue_o),
        .rob_enq_i    (rob_enqueue_o),
        .alu_enq_i    (rs_alu_enqueue_o),
        .muldiv_enq_i (rs_muldiv_enqueue_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3,
                                                input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OP_REG};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] u_type_word(input logic [19:0] imm, input logic [4:0] rd,
                                                input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    // register-file answers and the rob tail are random per row
    task automatic push_row(input logic [31:0] inst_w, input logic [31:0] pc_w,
                            input logic [3:0] flags_w, input logic [1:0] dest_w,
                            input logic [4:0] rd_w, input logic [31:0] rd_v_w,
                            input logic f7_w, input logic s1_sel,
                            input logic [1:0] s2_sel, input logic [31:0] imm_w);
        row_t        r;
        logic [31:0] rnd;
        rnd       = $random(seed);
        r.inst    = inst_w;
        r.pc      = pc_w;
        r.flags   = flags_w;
        r.tail    = rnd[3:0];
        r.rs1_v   = $random(seed);
        r.rs2_v   = $random(seed);
        r.rs1_ren = rnd[8];
        r.rs2_ren = rnd[9];
        r.dest    = dest_w;
        r.rd      = rd_w;
        r.rd_v    = rd_v_w;
        r.f7      = f7_w;
        r.s1_ren  = s1_sel ? r.rs1_ren : 1'b0;
        r.s1_data = s1_sel ? r.rs1_v : 32'h0;
        case (s2_sel)
            S_REG: begin
                r.s2_ren  = r.rs2_ren;
                r.s2_data = r.rs2_v;
            end
            S_IMM: begin
                r.s2_ren  = 1'b0;
                r.s2_data = imm_w;
            end
            default: begin
                r.s2_ren  = 1'b0;
                r.s2_data = 32'h0;
            end
        endcase
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [31:0] add_w;
        logic [31:0] mul_w;
        add_w = r_type_word(7'h00, 5'd14, 5'd13, 3'b000, 5'd12);
        mul_w = r_type_word(7'h01, 5'd17, 5'd16, 3'b000, 5'd15);
        // rob-only lui, auipc and jal
        push_row(u_type_word(20'h12345, 5'd5, `OP_LUI), 32'h0, 4'b0000, D_ROB, 5'd5,
                 32'h1234_5000, 1'b0, 1'b0, S_ZERO, 32'h0);
        push_row(u_type_word(20'h00001, 5'd6, `OP_AUIPC), 32'h100, 4'b0000, D_ROB, 5'd6,
                 32'h0000_1100, 1'b0, 1'b0, S_ZERO, 32'h0);
        push_row(u_type_word(20'h00800, 5'd1, `OP_JAL), 32'h200, 4'b0000, D_ROB, 5'd1,
                 32'h0000_0204, 1'b0, 1'b0, S_ZERO, 32'h0);
        // addi x7, x8, -5 and srai x9, x0, 3
        push_row(i_type_word(12'hffb, 5'd8, 3'b000, 5'd7, `OP_IMM), 32'h0, 4'b0000, D_ALU,
                 5'd7, 32'h0, 1'b0, 1'b1, S_IMM, 32'hffff_fffb);
        push_row(i_type_word(12'h403, 5'd0, `F3_SR, 5'd9, `OP_IMM), 32'h0, 4'b0000, D_ALU,
                 5'd9, 32'h0, 1'b1, 1'b0, S_IMM, 32'h0000_0403);
        // sub x10, x11, x0 then add, mul
        push_row(r_type_word(7'h20, 5'd0, 5'd11, 3'b000, 5'd10), 32'h0, 4'b0000, D_ALU,
                 5'd10, 32'h0, 1'b1, 1'b1, S_ZERO, 32'h0);
        push_row(add_w, 32'h0, 4'b0000, D_ALU, 5'd12, 32'h0, 1'b0, 1'b1, S_REG, 32'h0);
        push_row(mul_w, 32'h0, 4'b0000, D_MD, 5'd15, 32'h0, 1'b0, 1'b1, S_REG, 32'h0);
        push_row(r_type_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd0), 32'h0, 4'b0000, D_ALU,
                 5'd0, 32'h0, 1'b0, 1'b1, S_REG, 32'h0);
        // back-pressure rows
        push_row(add_w, 32'h0, 4'b1000, D_NONE, 5'd12, 32'h0, 1'b0, 1'b1, S_REG, 32'h0);
        push_row(add_w, 32'h0, 4'b0100, D_NONE, 5'd12, 32'h0, 1'b0, 1'b1, S_REG, 32'h0);
        push_row(add_w, 32'h0, 4'b0010, D_ALU, 5'd12, 32'h0, 1'b0, 1'b1, S_REG, 32'h0);
        push_row(mul_w, 32'h0, 4'b0010, D_NONE, 5'd15, 32'h0, 1'b0, 1'b1, S_REG, 32'h0);
        push_row(mul_w, 32'h0, 4'b0100, D_MD, 5'd15, 32'h0, 1'b0, 1'b1, S_REG, 32'h0);
        push_row(u_type_word(20'hfffff, 5'd3, `OP_LUI), 32'h0, 4'b0110, D_ROB, 5'd3,
                 32'hffff_f000, 1'b0, 1'b0, S_ZERO, 32'h0);
        // empty queue, lw x5, 0(x1) and a stalled lui
        push_row(add_w, 32'h0, 4'b0001, D_NONE, 5'd12, 32'h0, 1'b0, 1'b1, S_REG, 32'h0);
        push_row(i_type_word(12'h000, 5'd1, 3'b010, 5'd5, 7'b0000011), 32'h0, 4'b0000, D_NONE,
                 5'd5, 32'h0, 1'b0, 1'b1, S_ZERO, 32'h0);
        push_row(u_type_word(20'h12345, 5'd5, `OP_LUI), 32'h0, 4'b1000, D_NONE, 5'd5,
                 32'h0, 1'b0, 1'b0, S_ZERO, 32'h0);
        // remu x20, x0, x21
        push_row(r_type_word(7'h01, 5'd21, 5'd0, 3'b111, 5'd20), 32'h0, 4'b0000, D_MD,
                 5'd20, 32'h0, 1'b0, 1'b0, S_REG, 32'h0);
    endtask

    task automatic compare_field(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic apply_row(input row_t r);
        inst           = r.inst;
        pc             = r.pc;
        {rob_full, rs_alu_full, rs_muldiv_full, inst_empty} = r.flags;
        rob_tail       = r.tail;
        rs1_renamed    = r.rs1_ren;
        rs1_v          = r.rs1_v;
        rs2_renamed    = r.rs2_ren;
        rs2_v          = r.rs2_v;
    endtask

    // dequeue and rename are checked before the rising edge
    task automatic check_comb(input row_t r);
        logic go;
        go = (r.dest != D_NONE);
        compare_field("inst_dequeue", inst_dequeue, go);
        compare_field("reg_r", reg_r, go && (r.rd != 5'd0));
        compare_field("rs1_s", rs1_s, r.inst[19:15]);
        compare_field("rs2_s", rs2_s, r.inst[24:20]);
        if (go && (r.rd != 5'd0)) begin
            compare_field("rd_r", rd_r, r.rd);
            compare_field("rob_r", rob_r, r.tail);
        end
    endtask

    task automatic check_regs(input row_t r);
        compare_field("rob_enqueue", rob_enqueue, r.dest != D_NONE);
        compare_field("rs_alu_enqueue", rs_alu_enqueue, r.dest == D_ALU);
        compare_field("rs_muldiv_enqueue", rs_muldiv_enqueue, r.dest == D_MD);
        if (r.dest != D_NONE) begin
            compare_field("rob valid", rob_entry.valid, r.dest == D_ROB);
            compare_field("rob rd_valid", rob_entry.rd_valid, r.dest == D_ROB);
            compare_field("rob regf_we", rob_entry.regf_we, 1'b1);
            compare_field("rob rd_s", rob_entry.rd_s, r.rd);
            compare_field("rs valid", rs_entry.valid, r.dest == D_ALU || r.dest == D_MD);
        end
        if (r.dest == D_ROB) begin
            compare_field("rob rd_v", rob_entry.rd_v, r.rd_v);
        end
        if (r.dest == D_ALU || r.dest == D_MD) begin
            compare_field("rs funct3", rs_entry.funct3, r.inst[14:12]);
            compare_field("rs funct7", rs_entry.funct7, r.f7);
            compare_field("rs1_renamed", rs_entry.rs1_renamed, r.s1_ren);
            compare_field("rs1_data", rs_entry.rs1_data, r.s1_data);
            compare_field("rs2_renamed", rs_entry.rs2_renamed, r.s2_ren);
            compare_field("rs2_data", rs_entry.rs2_data, r.s2_data);
            compare_field("rob_id", rs_entry.rob_id, r.tail);
        end
    endtask

    // watchdog sized from the table
    initial begin
        wait (table_ready);
        #((rows.size() + 20) * CLK_PERIOD);
        $display("timeout: the table did not complete within the expected time");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rst            = 1'b1;
        inst           = '0;
        pc             = '0;
        inst_empty     = 1'b1;
        rob_full       = 1'b0;
        rs_alu_full    = 1'b0;
        rs_muldiv_full = 1'b0;
        rob_tail       = '0;
        rs1_renamed    = 1'b0;
        rs1_v          = '0;
        rs2_renamed    = 1'b0;
        rs2_v          = '0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        compare_field("rob_enqueue after reset", rob_enqueue, 1'b0);
        compare_field("rs_alu_enqueue after reset", rs_alu_enqueue, 1'b0);
        compare_field("rs_muldiv_enqueue after reset", rs_muldiv_enqueue, 1'b0);
        compare_field("rs_entry after reset", |rs_entry, 1'b0);
        compare_field("rob_entry after reset", |rob_entry, 1'b0);
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
            #1;
            check_comb(rows[i]);
            @(negedge clk);
            check_regs(rows[i]);
        end
        errors += u_dut.u_props.fail_count;
        $display("%0d checks, %0d errors, %0d property failures", checks, errors,
                 u_dut.u_props.fail_count);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
hdl/rv32_dispatch_pkg.sv
hdl/inst_decoder.sv
hdl/dispatch_ctrl.sv
hdl/dispatch_stage.sv
hdl/decode_dispatch.sv
test/decode_dispatch_props.sv
test/tb_decode_dispatch.sv

// ==== Bender.yml ====
package:
  name: decode_dispatch

sources:
  - include_dirs:
      - include
    files:
      - hdl/rv32_dispatch_pkg.sv
      - hdl/inst_decoder.sv
      - hdl/dispatch_ctrl.sv
      - hdl/dispatch_stage.sv
      - hdl/decode_dispatch.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/decode_dispatch_props.sv
      - test/tb_decode_dispatch.sv
